//--- Makefile
# Verilator build and run of the SPI command slave testbench

VERILATOR ?= verilator
TOP       ?= spi_cmd_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

BIN  := $(BUILD_DIR)/V$(TOP)
SRCS := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if grep -q "Errors found" $(LOG); then echo "simulation failed"; exit 1; fi; \
	exit $$rc

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- compile.f
hdl/spi_cmd_pkg.sv
hdl/word_ram.sv
hdl/spi_slave.sv
hdl/cmd_fsm.sv
hdl/snap_timer.sv
hdl/spi_cmd_top.sv
test/spi_cmd_tb.sv

//--- hdl/cmd_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module cmd_fsm #(
   parameter int SNAP_DEPTH = 16
) (
   input  wire logic                                    clk,
   input  wire logic                                    reset,
   input  wire logic                                    rx_valid,
   input  wire spi_cmd_pkg::spi_frame_t                 rx_frame,
   output logic                                         tx_load,
   output logic [spi_cmd_pkg::FRAME_BITS-1:0]           tx_word,
   output logic                                         vec_we,
   output logic [$clog2(spi_cmd_pkg::VEC_LEN)-1:0]      vec_waddr,
   output spi_cmd_pkg::vec_word_t                       vec_wdata,
   output logic [$clog2(spi_cmd_pkg::VEC_LEN)-1:0]      vec_raddr,
   input  wire spi_cmd_pkg::vec_word_t                  vec_rdata,
   output logic [$clog2(SNAP_DEPTH)-1:0]                snap_raddr,
   input  wire spi_cmd_pkg::snap_word_t                 snap_rdata,
   input  wire logic                                    snap_busy,
   output logic                                         snap_arm,
   output logic [2:0]                                   led
);
   import spi_cmd_pkg::*;

   localparam int VEC_AW  = $clog2(VEC_LEN);
   localparam int SNAP_AW = $clog2(SNAP_DEPTH);

   typedef enum logic [1:0] {S_IDLE, S_REPLY, S_VEC_WR, S_VEC_RD} state_t;

   state_t                state;
   state_t                from_q;
   spi_frame_t            frame_q;
   logic [VEC_AW:0]       vec_idx;
   logic                  last_elem;
   logic [15:0]           inv_reg;
   logic [SNAP_AW-1:0]    snap_ptr;
   logic [FRAME_BITS-1:0] reply;

   // element frames write straight from the slave
   assign vec_we     = rx_valid && (state == S_VEC_WR);
   assign vec_wdata  = rx_frame.payload;
   assign vec_waddr  = vec_idx[VEC_AW-1:0];
   assign vec_raddr  = vec_idx[VEC_AW-1:0];
   assign snap_raddr = snap_ptr;
   assign last_elem  = (vec_idx == (VEC_AW + 1)'(VEC_LEN - 1));

   // read pointers are stable long before the reply, so rdata is valid here
   always_comb begin
      reply = '0;
      if (from_q == S_VEC_RD) begin
         reply = FRAME_BITS'(vec_rdata);
      end else if (from_q == S_IDLE) begin
         case (frame_q.opcode)
            OP_RD_INV:  reply = FRAME_BITS'(inv_reg);
            OP_RD_LED:  reply = FRAME_BITS'(led);
            OP_RD_SNAP: reply = FRAME_BITS'({snap_busy, snap_rdata});
            default:    reply = '0;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= S_IDLE;
         from_q   <= S_IDLE;
         vec_idx  <= '0;
         inv_reg  <= '0;
         snap_ptr <= '0;
         led      <= '0;
         tx_load  <= 1'b0;
         snap_arm <= 1'b0;
      end else begin
         tx_load  <= 1'b0;
         snap_arm <= 1'b0;
         case (state)
            S_REPLY: begin
               tx_load <= 1'b1;
               state   <= S_IDLE;
               if (from_q != S_IDLE) begin
                  // element frame, opcode is ignored
                  vec_idx <= vec_idx + 1'b1;
                  if (!last_elem) begin
                     state <= from_q;
                  end
               end else begin
                  case (frame_q.opcode)
                     OP_INIT: begin
                        led      <= '0;
                        inv_reg  <= '0;
                        snap_ptr <= '0;
                     end
                     OP_WR_INV: inv_reg <= ~frame_q.payload[15:0];
                     OP_WR_LED: led <= frame_q.payload[2:0];
                     OP_WR_VEC: begin
                        vec_idx <= '0;
                        state   <= S_VEC_WR;
                     end
                     OP_RD_VEC: begin
                        vec_idx <= '0;
                        state   <= S_VEC_RD;
                     end
                     OP_ARM: snap_arm <= 1'b1;
                     OP_RD_SNAP: begin
                        snap_ptr <= (snap_ptr == SNAP_AW'(SNAP_DEPTH - 1)) ? '0
                                                                          : snap_ptr + 1'b1;
                     end
                     default: ;
                  endcase
               end
            end
            default: begin
               if (rx_valid) begin
                  from_q <= state;
                  state  <= S_REPLY;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rx_valid) begin
         frame_q <= rx_frame;
      end
      if (state == S_REPLY) begin
         tx_word <= reply;
      end
   end

   assert property (@(posedge clk) disable iff (reset)
      (state == S_VEC_WR || state == S_VEC_RD) |-> (vec_idx < VEC_LEN));

   // one clock for the frame latch, one for the RAM read
   assert property (@(posedge clk) disable iff (reset) rx_valid |-> ##2 tx_load);

endmodule

`default_nettype wire

//--- hdl/snap_timer.sv
`timescale 1ns/1ns
`default_nettype none

module snap_timer #(
   parameter int SNAP_DEPTH = 16,
   parameter int SAMPLE_DIV = 4
) (
   input  wire logic                      clk,
   input  wire logic                      reset,
   input  wire logic                      arm,
   input  wire logic                      sample_in,
   output logic                           busy,
   output logic                           we,
   output logic [$clog2(SNAP_DEPTH)-1:0]  waddr,
   output spi_cmd_pkg::snap_word_t        wdata
);
   import spi_cmd_pkg::*;

   localparam int DIV_W   = $clog2(SAMPLE_DIV + 1);
   localparam int SNAP_AW = $clog2(SNAP_DEPTH);
   localparam int SW      = $bits(snap_word_t);

   logic [1:0]       sample_sync;
   logic [DIV_W-1:0] div_cnt;
   logic [3:0]       bit_cnt;
   logic [SW-2:0]    shreg;
   logic             tick;

   // both counters rest at zero while idle
   assign tick  = (div_cnt == DIV_W'(SAMPLE_DIV - 1));
   // 16th sample goes straight into the word being written
   assign we    = tick && (bit_cnt == 4'hf);
   assign wdata = {sample_sync[1], shreg};

   always_ff @(posedge clk) begin
      sample_sync <= {sample_sync[0], sample_in};
      if (tick) begin
         shreg <= {sample_sync[1], shreg[SW-2:1]};
      end
   end

   // arm restarts a running capture too
   always_ff @(posedge clk) begin
      if (reset) begin
         busy    <= 1'b0;
         div_cnt <= '0;
         bit_cnt <= '0;
         waddr   <= '0;
      end else if (arm) begin
         busy    <= 1'b1;
         div_cnt <= '0;
         bit_cnt <= '0;
         waddr   <= '0;
      end else if (busy) begin
         div_cnt <= tick ? '0 : div_cnt + 1'b1;
         if (tick) begin
            bit_cnt <= bit_cnt + 1'b1;
         end
         if (we) begin
            waddr <= waddr + 1'b1;
            if (waddr == SNAP_AW'(SNAP_DEPTH - 1)) begin
               busy <= 1'b0;
            end
         end
      end
   end

   assert property (@(posedge clk) disable iff (reset) we |-> busy);

endmodule

`default_nettype wire

//--- hdl/spi_cmd_pkg.sv
`default_nettype none

package spi_cmd_pkg;

   localparam int FRAME_BITS = 32;

   // number of vector elements, fixed by the protocol
   localparam int VEC_LEN = 4;

   typedef enum logic [7:0] {
      OP_NOP     = 8'h00,
      OP_INIT    = 8'h01,
      OP_WR_INV  = 8'h02,
      OP_RD_INV  = 8'h03,
      OP_WR_LED  = 8'h04,
      OP_RD_LED  = 8'h05,
      OP_WR_VEC  = 8'h06,
      OP_RD_VEC  = 8'h07,
      OP_RD_SNAP = 8'h08,
      OP_ARM     = 8'h09
   } opcode_t;

   // one vector element
   typedef logic [23:0] vec_word_t;

   // 16 samples, earliest in bit 0
   typedef logic [15:0] snap_word_t;

   // opcode goes out first on the wire
   typedef struct packed {
      opcode_t     opcode;
      logic [23:0] payload;
   } spi_frame_t;

endpackage

`default_nettype wire

//--- hdl/spi_cmd_top.sv
`timescale 1ns/1ns
`default_nettype none

module spi_cmd_top #(
   parameter int SNAP_DEPTH = 16,
   parameter int SAMPLE_DIV = 4
) (
   input  wire logic  clk,
   input  wire logic  reset,
   input  wire logic  spi_sck,
   input  wire logic  spi_ss,
   input  wire logic  spi_mosi,
   output logic       spi_miso,
   input  wire logic  sample_in,
   output logic       led_r,
   output logic       led_g,
   output logic       led_b
);
   import spi_cmd_pkg::*;

   localparam int VEC_AW  = $clog2(VEC_LEN);
   localparam int SNAP_AW = $clog2(SNAP_DEPTH);

   logic                  rx_valid;
   spi_frame_t            rx_frame;
   logic                  tx_load;
   logic [FRAME_BITS-1:0] tx_word;

   logic                  vec_we;
   logic [VEC_AW-1:0]     vec_waddr;
   logic [VEC_AW-1:0]     vec_raddr;
   vec_word_t             vec_wdata;
   vec_word_t             vec_rdata;

   logic                  snap_we;
   logic                  snap_arm;
   logic                  snap_busy;
   logic [SNAP_AW-1:0]    snap_waddr;
   logic [SNAP_AW-1:0]    snap_raddr;
   snap_word_t            snap_wdata;
   snap_word_t            snap_rdata;

   logic [2:0]            led;

   spi_slave u_spi (
      .clk      (clk),
      .reset    (reset),
      .spi_sck  (spi_sck),
      .spi_ss   (spi_ss),
      .spi_mosi (spi_mosi),
      .spi_miso (spi_miso),
      .rx_valid (rx_valid),
      .rx_frame (rx_frame),
      .tx_load  (tx_load),
      .tx_word  (tx_word)
   );

   cmd_fsm #(.SNAP_DEPTH(SNAP_DEPTH)) u_fsm (
      .clk        (clk),
      .reset      (reset),
      .rx_valid   (rx_valid),
      .rx_frame   (rx_frame),
      .tx_load    (tx_load),
      .tx_word    (tx_word),
      .vec_we     (vec_we),
      .vec_waddr  (vec_waddr),
      .vec_wdata  (vec_wdata),
      .vec_raddr  (vec_raddr),
      .vec_rdata  (vec_rdata),
      .snap_raddr (snap_raddr),
      .snap_rdata (snap_rdata),
      .snap_busy  (snap_busy),
      .snap_arm   (snap_arm),
      .led        (led)
   );

   snap_timer #(.SNAP_DEPTH(SNAP_DEPTH), .SAMPLE_DIV(SAMPLE_DIV)) u_timer (
      .clk       (clk),
      .reset     (reset),
      .arm       (snap_arm),
      .sample_in (sample_in),
      .busy      (snap_busy),
      .we        (snap_we),
      .waddr     (snap_waddr),
      .wdata     (snap_wdata)
   );

   word_ram #(.payload_t(vec_word_t), .DEPTH(VEC_LEN)) u_vec_ram (
      .clk   (clk),
      .we    (vec_we),
      .waddr (vec_waddr),
      .wdata (vec_wdata),
      .raddr (vec_raddr),
      .rdata (vec_rdata)
   );

   word_ram #(.payload_t(snap_word_t), .DEPTH(SNAP_DEPTH)) u_snap_ram (
      .clk   (clk),
      .we    (snap_we),
      .waddr (snap_waddr),
      .wdata (snap_wdata),
      .raddr (snap_raddr),
      .rdata (snap_rdata)
   );

   // board LEDs light on a low pin
   assign led_r = ~led[0];
   assign led_g = ~led[1];
   assign led_b = ~led[2];

endmodule

`default_nettype wire

//--- hdl/spi_slave.sv
`timescale 1ns/1ns
`default_nettype none

module spi_slave (
   input  wire logic                                clk,
   input  wire logic                                reset,
   input  wire logic                                spi_sck,
   input  wire logic                                spi_ss,
   input  wire logic                                spi_mosi,
   output logic                                     spi_miso,
   output logic                                     rx_valid,
   output spi_cmd_pkg::spi_frame_t                  rx_frame,
   input  wire logic                                tx_load,
   input  wire logic [spi_cmd_pkg::FRAME_BITS-1:0]  tx_word
);
   import spi_cmd_pkg::*;

   localparam int BIT_W = $clog2(FRAME_BITS);

   logic [1:0]            sck_sync;
   logic [1:0]            ss_sync;
   logic [1:0]            mosi_sync;
   logic                  sck_q;
   logic                  ss_q;
   logic                  sck_rise;
   logic                  sck_fall;
   logic                  ss_fall;
   logic [BIT_W-1:0]      bit_cnt;
   logic [FRAME_BITS-1:0] rx_shift;
   logic [FRAME_BITS-1:0] tx_buf;
   logic [FRAME_BITS-1:0] tx_shift;
   logic                  tx_pending;
   logic                  done_p;
   logic                  done_q;

   // two flops per pin, then one more for edge detect
   always_ff @(posedge clk) begin
      if (reset) begin
         sck_sync  <= 2'b00;
         ss_sync   <= 2'b11;
         mosi_sync <= 2'b00;
         sck_q     <= 1'b0;
         ss_q      <= 1'b1;
      end else begin
         sck_sync  <= {sck_sync[0], spi_sck};
         ss_sync   <= {ss_sync[0], spi_ss};
         mosi_sync <= {mosi_sync[0], spi_mosi};
         sck_q     <= sck_sync[1];
         ss_q      <= ss_sync[1];
      end
   end

   assign sck_rise = sck_sync[1] & ~sck_q;
   assign sck_fall = ~sck_sync[1] & sck_q;
   assign ss_fall  = ~ss_sync[1] & ss_q;

   // bit count restarts while ss is high
   always_ff @(posedge clk) begin
      if (reset) begin
         bit_cnt  <= '0;
         done_p   <= 1'b0;
         done_q   <= 1'b0;
         rx_valid <= 1'b0;
      end else begin
         done_p   <= 1'b0;
         done_q   <= done_p;
         rx_valid <= done_q;
         if (ss_sync[1]) begin
            bit_cnt <= '0;
         end else if (sck_rise) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == BIT_W'(FRAME_BITS - 1)) begin
               done_p <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (sck_rise && !ss_sync[1]) begin
         rx_shift <= {rx_shift[FRAME_BITS-2:0], mosi_sync[1]};
      end
      if (done_q) begin
         rx_frame <= spi_frame_t'(rx_shift);
      end
      if (tx_load) begin
         tx_buf <= tx_word;
      end
   end

   // reply goes out only if loaded since the last frame
   always_ff @(posedge clk) begin
      if (reset) begin
         tx_pending <= 1'b0;
         tx_shift   <= '0;
      end else begin
         if (tx_load) begin
            tx_pending <= 1'b1;
         end else if (ss_fall) begin
            tx_pending <= 1'b0;
         end
         if (ss_fall) begin
            tx_shift <= tx_pending ? tx_buf : '0;
         end else if (sck_fall && !ss_sync[1]) begin
            tx_shift <= {tx_shift[FRAME_BITS-2:0], 1'b0};
         end
      end
   end

   assign spi_miso = tx_shift[FRAME_BITS-1];

   assert property (@(posedge clk) disable iff (reset) rx_valid |=> !rx_valid);

endmodule

`default_nettype wire

//--- hdl/word_ram.sv
`timescale 1ns/1ns
`default_nettype none

module word_ram #(
   parameter type payload_t = logic [7:0],
   parameter int  DEPTH     = 4
) (
   input  wire logic                      clk,
   input  wire logic                      we,
   input  wire logic [$clog2(DEPTH)-1:0]  waddr,
   input  wire payload_t                  wdata,
   input  wire logic [$clog2(DEPTH)-1:0]  raddr,
   output payload_t                       rdata
);

   payload_t mem [DEPTH];

   // read data lags raddr by one clock
   always_ff @(posedge clk) begin
      if (we) begin
         mem[waddr] <= wdata;
      end
      rdata <= mem[raddr];
   end

   assert property (@(posedge clk) we |-> (waddr < DEPTH));

endmodule

`default_nettype wire

//--- test/spi_cmd_tb.sv
`timescale 1ns/1ns
`default_nettype none

module spi_cmd_tb;
   import spi_cmd_pkg::*;

   localparam int SNAP_DEPTH   = 16;
   localparam int SAMPLE_DIV   = 4;
   localparam int HALF_SCK     = 4;
   localparam int GAP_CLKS     = 12;
   localparam int N_FRAMES     = 55;
   // 16 words of 16 samples each, plus slack for the arm latency
   localparam int CAPTURE_CLKS = SNAP_DEPTH * 16 * SAMPLE_DIV + 200;
   localparam int MAX_CYCLES   = 2 * (N_FRAMES * 160 + CAPTURE_CLKS);

   logic        clk;
   logic        reset;
   logic        spi_sck;
   logic        spi_ss;
   logic        spi_mosi;
   logic        spi_miso;
   logic        sample_in;
   logic        led_r;
   logic        led_g;
   logic        led_b;

   int          cycles = 0;
   int          errors;
   int          checks;
   int          test_errors;
   logic [31:0] lfsr_state;

   // reference model state
   logic [2:0]  m_led;
   logic [15:0] m_inv;
   vec_word_t   m_vec [VEC_LEN];
   snap_word_t  m_snap [SNAP_DEPTH];
   int          m_snap_ptr;
   int          m_wr_left;
   int          m_rd_left;
   logic        m_sample;
   logic [31:0] m_expect;

   spi_cmd_top #(.SNAP_DEPTH(SNAP_DEPTH), .SAMPLE_DIV(SAMPLE_DIV)) UUT (
      .clk       (clk),
      .reset     (reset),
      .spi_sck   (spi_sck),
      .spi_ss    (spi_ss),
      .spi_mosi  (spi_mosi),
      .spi_miso  (spi_miso),
      .sample_in (sample_in),
      .led_r     (led_r),
      .led_g     (led_g),
      .led_b     (led_b)
   );

   initial clk = 1'b0;
   always #4 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout: run still going after %0d clock cycles", cycles);
         $display("Errors found");
         $finish;
      end
   end

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic [31:0] n;
      n = s >> 1;
      if (s[0]) begin
         n = n ^ 32'h8020_0003;
      end
      return n;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr_state[0]};
         lfsr_state = lfsr_next(lfsr_state);
      end
      return v;
   endfunction

   // works out the reply this frame should get on the next one
   task automatic model_frame(input opcode_t op, input logic [23:0] payload);
      m_expect = '0;
      if (m_wr_left > 0) begin
         m_vec[VEC_LEN - m_wr_left] = payload;
         m_wr_left--;
      end else if (m_rd_left > 0) begin
         m_expect = 32'(m_vec[VEC_LEN - m_rd_left]);
         m_rd_left--;
      end else begin
         case (op)
            OP_INIT: begin
               m_led      = '0;
               m_inv      = '0;
               m_snap_ptr = 0;
            end
            OP_WR_INV: m_inv = ~payload[15:0];
            OP_RD_INV: m_expect = 32'(m_inv);
            OP_WR_LED: m_led = payload[2:0];
            OP_RD_LED: m_expect = 32'(m_led);
            OP_WR_VEC: m_wr_left = VEC_LEN;
            OP_RD_VEC: m_rd_left = VEC_LEN;
            OP_ARM: begin
               for (int i = 0; i < SNAP_DEPTH; i++) begin
                  m_snap[i] = {16{m_sample}};
               end
            end
            OP_RD_SNAP: begin
               // capture has finished by the time reads start, busy low
               m_expect   = {15'd0, 1'b0, m_snap[m_snap_ptr]};
               m_snap_ptr = (m_snap_ptr + 1) % SNAP_DEPTH;
            end
            default: ;
         endcase
      end
   endtask

   // mode 0 host, msb first, sample miso just before each rising sck
   task automatic spi_transfer(input logic [31:0] tx, output logic [31:0] rx);
      rx = '0;
      @(negedge clk);
      spi_ss   = 1'b0;
      spi_mosi = tx[31];
      for (int i = 31; i >= 0; i--) begin
         repeat (HALF_SCK) @(negedge clk);
         rx[i]   = spi_miso;
         spi_sck = 1'b1;
         repeat (HALF_SCK) @(negedge clk);
         spi_sck = 1'b0;
         if (i > 0) begin
            spi_mosi = tx[i-1];
         end
      end
      repeat (HALF_SCK) @(negedge clk);
      spi_ss = 1'b1;
      repeat (GAP_CLKS) @(negedge clk);
   endtask

   task automatic send_frame(input opcode_t op, input logic [23:0] payload);
      spi_frame_t  f;
      logic [31:0] got;
      logic [31:0] want;
      f.opcode  = op;
      f.payload = payload;
      want      = m_expect;
      spi_transfer(f, got);
      checks++;
      if (got !== want) begin
         errors++;
         $display("** Error at %0t ns: spi_miso word is %h, expected %h (opcode %h sent)",
                  $time, got, want, op);
      end
      model_frame(op, payload);
   endtask

   task automatic check_leds();
      checks++;
      if ({led_b, led_g, led_r} !== ~m_led) begin
         errors++;
         $display("** Error at %0t ns: {led_b,led_g,led_r} is %b, expected %b",
                  $time, {led_b, led_g, led_r}, ~m_led);
      end
   endtask

   task automatic end_test(input int num, input string name);
      $display("test %0d %s: %0d errors", num, name, errors - test_errors);
      test_errors = errors;
   endtask

   initial begin
      logic [31:0] r;
      reset       = 1'b1;
      spi_sck     = 1'b0;
      spi_ss      = 1'b1;
      spi_mosi    = 1'b0;
      sample_in   = 1'b0;
      errors      = 0;
      checks      = 0;
      test_errors = 0;
      lfsr_state  = 32'hdedb;
      m_led       = '0;
      m_inv       = '0;
      m_snap_ptr  = 0;
      m_wr_left   = 0;
      m_rd_left   = 0;
      m_sample    = 1'b0;
      m_expect    = '0;
      repeat (3) @(negedge clk);
      reset = 1'b0;
      repeat (2) @(negedge clk);

      check_leds();
      send_frame(OP_NOP, '0);
      send_frame(OP_RD_LED, '0);
      send_frame(OP_NOP, '0);
      end_test(1, "reset defaults");

      for (int k = 0; k < 8; k++) begin
         r = rand_bits(3);
         send_frame(OP_WR_LED, {21'd0, r[2:0]});
         check_leds();
         send_frame(OP_RD_LED, '0);
      end
      send_frame(OP_NOP, '0);
      end_test(2, "LED write and read");

      r = rand_bits(16);
      send_frame(OP_WR_INV, {8'h00, r[15:0]});
      send_frame(OP_RD_INV, '0);
      send_frame(OP_INIT, '0);
      check_leds();
      send_frame(OP_RD_INV, '0);
      send_frame(OP_NOP, '0);
      end_test(3, "inversion register and init");

      // element frames carry a nop opcode, only the payload counts
      send_frame(OP_WR_VEC, '0);
      for (int k = 0; k < VEC_LEN; k++) begin
         r = rand_bits(24);
         send_frame(OP_NOP, r[23:0]);
      end
      send_frame(OP_RD_VEC, '0);
      for (int k = 0; k < VEC_LEN; k++) begin
         send_frame(OP_NOP, '0);
      end
      send_frame(OP_NOP, '0);
      end_test(4, "vector write and read");

      r         = rand_bits(1);
      m_sample  = r[0];
      sample_in = r[0];
      send_frame(OP_ARM, '0);
      repeat (CAPTURE_CLKS) @(negedge clk);
      // one extra read to see the pointer wrap
      for (int k = 0; k < SNAP_DEPTH + 1; k++) begin
         send_frame(OP_RD_SNAP, '0);
      end
      send_frame(OP_NOP, '0);
      end_test(5, "snapshot capture");

      $display("5 tests, %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire
